//--- vlog.f
common/nocPkg.sv
rtl/inputFifo.sv
arbiter/grantBudget.sv
arbiter/switchArbiter.sv
rtl/outputLink.sv
rtl/routerOutputPort.sv
verification/flitModel.sv
verification/routerOutputPortTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= routerOutputPortTb
RTL_TOP ?= routerOutputPort
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
PASS_MSG ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR)

//--- verification/routerOutputPortTb.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPortTb;

  localparam int fifoDepth = 4;
  localparam int lengthWidth = 12;
  localparam int waitLimit = 2000;

  logic                        clk;
  logic                        rst;
  nocPkg::wbReqT               inReq [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] inAck;
  nocPkg::wbReqT               outReq;
  logic                        outAck;

  logic  ackHold;
  logic  contigCheck;
  int    ownerSrc;
  int    seqNo [nocPkg::numPorts];
  int    srcOrder [$];
  int    testsRun;
  int    testsFailed;
  string abortReason;
  event  runAborted;

  routerOutputPort #(
    .fifoDepth  (fifoDepth),
    .lengthWidth(lengthWidth)
  ) dut_i (
    .clk   (clk),
    .rst   (rst),
    .inReq (inReq),
    .inAck (inAck),
    .outReq(outReq),
    .outAck(outAck)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // hands the reason to the abort process and parks the caller.
  task automatic failRun(input string reason);
    abortReason = reason;
    -> runAborted;
    forever @(posedge clk);
  endtask

  initial
  begin
    @(runAborted);
    $display("%s", abortReason);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    #2000000;
    failRun("the simulation ran past its overall time limit");
  end

  // one Wishbone write on port p, entered and left 2 ns after a rising edge.
  task automatic sendFlit(input int p, input nocPkg::flitT f);
    int t;
    flitModel::pushExpected(f);
    inReq[p] = '{1'b1, 1'b1, 1'b1, f};
    t = 0;
    do
    begin
      @(posedge clk);
      #2;
      t++;
    end while (!inAck[p] && t < waitLimit);
    if (!inAck[p])
      failRun($sformatf("port %0d never acknowledged a flit", p));
    @(posedge clk);
    #2;
    inReq[p] = '0;
  endtask

  task automatic sendPacket(input int p, input int nFlits, input int declLen, input bit withTail);
    nocPkg::flitT f;
    for (int i = 0; i < nFlits; i++)
    begin
      f.kind = (i == 0) ? nocPkg::kindHead : nocPkg::kindBody;
      if (withTail && i == nFlits - 1)
        f.kind = (i == 0) ? (nocPkg::kindHead | nocPkg::kindTail) : nocPkg::kindTail;
      f.length = (i == 0) ? 12'(declLen) : 12'd0;
      f.srcPort = nocPkg::portT'(p);
      f.data = 32'(seqNo[p]);
      seqNo[p]++;
      sendFlit(p, f);
    end
  endtask

  task automatic sendBurst(input int p, input int nPackets);
    int len;
    for (int i = 0; i < nPackets; i++)
    begin
      len = $urandom_range(4, 1);
      sendPacket(p, len, len, 1'b1);
    end
  endtask

  task automatic takeFlit(input nocPkg::flitT f);
    int src;
    src = int'(f.srcPort);
    srcOrder.push_back(src);
    if (contigCheck && ownerSrc >= 0 && src != ownerSrc)
      flitModel::checkCount(src, ownerSrc, "source inside another packet");
    if ((f.kind & nocPkg::kindHead) != 0 && (f.kind & nocPkg::kindTail) == 0)
      ownerSrc = src;
    else if ((f.kind & nocPkg::kindTail) != 0)
      ownerSrc = -1;
    flitModel::matchOutput(f);
  endtask

  // downstream router, acks each flit after 0 to 3 cycles.
  initial
  begin
    int delay;
    outAck = 1'b0;
    delay = -1;
    forever
    begin
      @(posedge clk);
      #2;
      outAck = 1'b0;
      if (outReq.stb)
        flitModel::checkCount(int'({outReq.cyc, outReq.we}), 3, "cyc and we beside stb");
      if (!ackHold && outReq.stb)
      begin
        if (delay < 0)
          delay = $urandom_range(3, 0);
        if (delay == 0)
        begin
          outAck = 1'b1;
          takeFlit(outReq.flit);
          delay = -1;
        end
        else
          delay--;
      end
    end
  end

  task automatic waitDrain();
    int t;
    t = 0;
    while (flitModel::recvCount < flitModel::sentCount && t < waitLimit * 4)
    begin
      @(posedge clk);
      #2;
      t++;
    end
    if (flitModel::recvCount < flitModel::sentCount)
      failRun("the output did not deliver every flit that was sent");
  endtask

  task automatic finishTest(input int num, input string name, input int errBefore);
    testsRun++;
    if (flitModel::errorCount != errBefore)
      testsFailed++;
    $display("test %0d %s: %s", num, name,
             (flitModel::errorCount == errBefore) ? "ok" : "FAILED");
  endtask

  initial
  begin
    int errBefore;
    int eastPos;
    void'($urandom(75730));
    rst = 1'b1;
    ackHold = 1'b0;
    contigCheck = 1'b0;
    ownerSrc = -1;
    testsRun = 0;
    testsFailed = 0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      inReq[p] = '0;
      seqNo[p] = 0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    errBefore = flitModel::errorCount;
    for (int i = 0; i < 5; i++)
    begin
      @(posedge clk);
      #2;
      flitModel::checkCount(int'(outReq.cyc), 0, "cyc after reset");
      flitModel::checkCount(int'(outReq.stb), 0, "stb after reset");
      flitModel::checkCount(int'(inAck), 0, "inAck after reset");
    end
    finishTest(1, "reset", errBefore);

    errBefore = flitModel::errorCount;
    contigCheck = 1'b1;
    sendBurst($urandom_range(4, 0), 6);
    waitDrain();
    finishTest(2, "single port", errBefore);

    errBefore = flitModel::errorCount;
    fork
      sendBurst(0, 5);
      sendBurst(1, 5);
      sendBurst(2, 5);
      sendBurst(3, 5);
      sendBurst(4, 5);
    join
    waitDrain();
    finishTest(3, "contiguity", errBefore);

    // all five flits land in the same cycle while the output is stalled.
    errBefore = flitModel::errorCount;
    ackHold = 1'b1;
    srcOrder.delete();
    fork
      sendPacket(0, 1, 1, 1'b1);
      sendPacket(1, 1, 1, 1'b1);
      sendPacket(2, 1, 1, 1'b1);
      sendPacket(3, 1, 1, 1'b1);
      sendPacket(4, 1, 1, 1'b1);
    join
    ackHold = 1'b0;
    waitDrain();
    flitModel::checkCount(srcOrder.size(), 5, "rotation flit count");
    for (int i = 0; i < 5 && i < srcOrder.size(); i++)
      flitModel::checkCount(srcOrder[i], i, "rotation source");
    finishTest(4, "rotation", errBefore);

    // north claims 3 flits but sends 6 with no tail, east waits behind it.
    errBefore = flitModel::errorCount;
    contigCheck = 1'b0;
    ackHold = 1'b1;
    srcOrder.delete();
    fork
      sendPacket(1, 6, 3, 1'b0);
      begin
        repeat (6) @(posedge clk);
        #2;
        sendPacket(2, 1, 1, 1'b1);
        ackHold = 1'b0;
      end
    join
    waitDrain();
    eastPos = -1;
    for (int i = srcOrder.size() - 1; i >= 0; i--)
    begin
      if (srcOrder[i] == 2)
        eastPos = i;
    end
    flitModel::checkCount(srcOrder.size(), 7, "budget cut flit count");
    flitModel::checkCount(eastPos, 3, "position of the waiting packet");
    finishTest(5, "budget cut", errBefore);

    errBefore = flitModel::errorCount;
    flitModel::checkCount(flitModel::recvCount, flitModel::sentCount, "flits received");
    flitModel::checkCount(flitModel::pendingCount(), 0, "flits left in the model");
    finishTest(6, "conservation", errBefore);

    $display("tests run %0d, tests failed %0d, check errors %0d, flits sent %0d, received %0d",
             testsRun, testsFailed, flitModel::errorCount,
             flitModel::sentCount, flitModel::recvCount);
    if (testsFailed == 0 && flitModel::errorCount == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
      failRun("one or more checks failed");
  end

endmodule

`default_nettype wire

//--- verification/flitModel.sv
`default_nettype none

package flitModel;

  // expected flits, one queue per source port.
  nocPkg::flitT expQ [nocPkg::numPorts][$];

  int errorCount = 0;
  int sentCount = 0;
  int recvCount = 0;

  task automatic pushExpected(input nocPkg::flitT f);
    expQ[int'(f.srcPort)].push_back(f);
    sentCount++;
  endtask

  task automatic checkFlit(input nocPkg::flitT got, input nocPkg::flitT exp, input string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s, got kind %b len %0d src %0d data %0d, %s",
               $time, what, got.kind, got.length, got.srcPort, got.data,
               $sformatf("expected kind %b len %0d src %0d data %0d",
                         exp.kind, exp.length, exp.srcPort, exp.data));
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string what);
    if (got != exp)
    begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // takes the oldest expected flit of the same source and compares.
  task automatic matchOutput(input nocPkg::flitT got);
    nocPkg::flitT exp;
    int src;
    src = int'(got.srcPort);
    recvCount++;
    if (src >= nocPkg::numPorts || expQ[src].size() == 0)
    begin
      errorCount++;
      $display("a flit from port %0d came out at %0t that was never sent", src, $time);
    end
    else
    begin
      exp = expQ[src].pop_front();
      checkFlit(got, exp, "output flit");
    end
  endtask

  function automatic int pendingCount();
    int total;
    total = 0;
    for (int p = 0; p < nocPkg::numPorts; p++)
      total += expQ[p].size();
    return total;
  endfunction

endpackage

`default_nettype wire

//--- rtl/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort #(
  parameter int fifoDepth = 4,
  parameter int lengthWidth = 12
) (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::wbReqT               inReq [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inAck,
  output nocPkg::wbReqT               outReq,
  input  logic                        outAck
);

  logic [nocPkg::numPorts-1:0] notEmpty;
  logic [nocPkg::numPorts-1:0] pop;
  nocPkg::flitT                heads [nocPkg::numPorts];
  nocPkg::flitT                grantedFlit;
  logic                        flitValid;
  logic                        accepted;

  // one buffer per input port.
  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gFifo
    inputFifo #(
      .fifoDepth(fifoDepth)
    ) fifo_i (
      .clk     (clk),
      .rst     (rst),
      .req     (inReq[p]),
      .ack     (inAck[p]),
      .pop     (pop[p]),
      .head    (heads[p]),
      .notEmpty(notEmpty[p])
    );
  end

  switchArbiter #(
    .lengthWidth(lengthWidth)
  ) arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .heads    (heads),
    .accepted (accepted),
    .pop      (pop),
    .flitValid(flitValid),
    .flit     (grantedFlit)
  );

  outputLink link_i (
    .clk      (clk),
    .rst      (rst),
    .flitValid(flitValid),
    .flit     (grantedFlit),
    .accepted (accepted),
    .req      (outReq),
    .ack      (outAck)
  );

endmodule

`default_nettype wire

//--- rtl/outputLink.sv
`timescale 1ns/1ps
`default_nettype none

module outputLink (
  input  logic          clk,
  input  logic          rst,
  input  logic          flitValid,
  input  nocPkg::flitT  flit,
  output logic          accepted,
  output nocPkg::wbReqT req,
  input  logic          ack
);

  nocPkg::flitT flitQ;
  logic         full;
  logic         release_;

  assign release_ = full && ack;

  // a new flit may enter while the old one leaves.
  assign accepted = flitValid && (!full || release_);

  always_ff @(posedge clk)
  begin
    if (rst)
      full <= 1'b0;
    else if (accepted)
      full <= 1'b1;
    else if (release_)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accepted)
      flitQ <= flit;
  end

  always_comb
  begin
    req.cyc = full;
    req.stb = full;
    req.we = full;
    req.flit = flitQ;
  end

  // downstream may only ack a request that is on the bus.
  ackNeedsStb: assert property (@(posedge clk) disable iff (rst)
    ack |-> req.stb);

endmodule

`default_nettype wire

//--- arbiter/switchArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module switchArbiter #(
  parameter int lengthWidth = 12
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] notEmpty,
  input  nocPkg::flitT                heads [nocPkg::numPorts],
  input  logic                        accepted,
  output logic [nocPkg::numPorts-1:0] pop,
  output logic                        flitValid,
  output nocPkg::flitT                flit
);

  // one-hot state, bit 0 is idle and bit p+1 means port p holds the output.
  localparam logic [5:0] idleState = 6'b000001;

  logic [5:0]                  state;
  logic [5:0]                  nextState;
  logic [nocPkg::numPorts-1:0] grantMask;
  logic                        granted;
  logic [2:0]                  holder;
  logic                        midPacket;
  logic                        isHead;
  logic                        isTail;
  logic                        holderSpent;
  logic                        holdGrant;
  logic [nocPkg::numPorts-1:0] budgetLoad;
  logic [nocPkg::numPorts-1:0] budgetSpent;
  logic [lengthWidth-1:0]      headLength;

  // first requesting port among span ports starting at start, else idle.
  function automatic logic [5:0] firstAfter(input logic [nocPkg::numPorts-1:0] reqs,
                                            input int start, input int span);
    logic [5:0] pick;
    int idx;
    pick = idleState;
    for (int off = span - 1; off >= 0; off--)
    begin
      idx = (start + off) % nocPkg::numPorts;
      if (reqs[idx])
        pick = 6'b000010 << idx;
    end
    return pick;
  endfunction

  assign grantMask = state[nocPkg::numPorts:1];
  assign granted = |grantMask;

  always_comb
  begin
    holder = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (grantMask[p])
        holder = 3'(p);
    end
  end

  assign flit = heads[holder];
  assign isHead = |(flit.kind & nocPkg::kindHead);
  assign isTail = |(flit.kind & nocPkg::kindTail);
  assign holderSpent = budgetSpent[holder];
  assign headLength = lengthWidth'(flit.length);

  // no flit is offered in the cycle the budget runs out.
  assign flitValid = granted && notEmpty[holder] && !holderSpent;

  assign pop = grantMask & {nocPkg::numPorts{accepted}};
  assign budgetLoad = pop & {nocPkg::numPorts{isHead}};

  always_comb
  begin
    holdGrant = !(accepted && isTail) && !holderSpent && (notEmpty[holder] || midPacket);
    if (state == idleState)
      nextState = firstAfter(notEmpty, 0, nocPkg::numPorts);
    else if (holdGrant)
      nextState = state;
    else
      // the released port is skipped, as in the rotation from idle.
      nextState = firstAfter(notEmpty, int'(holder) + 1, nocPkg::numPorts - 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idleState;
      midPacket <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (nextState != state)
        midPacket <= 1'b0;
      else if (accepted && isHead)
        midPacket <= !isTail;
      else if (accepted && isTail)
        midPacket <= 1'b0;
    end
  end

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gBudget
    grantBudget #(
      .lengthWidth(lengthWidth)
    ) budget_i (
      .clk   (clk),
      .rst   (rst),
      .load  (budgetLoad[p]),
      .length(headLength),
      .count (pop[p]),
      .spent (budgetSpent[p])
    );
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot(state) && ((pop & ~grantMask) == '0));

  // the link takes a flit only when one is offered.
  acceptOnlyOffered: assert property (@(posedge clk) disable iff (rst)
    accepted |-> flitValid);

endmodule

`default_nettype wire

//--- arbiter/grantBudget.sv
`timescale 1ns/1ps
`default_nettype none

module grantBudget #(
  parameter int lengthWidth = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  logic [lengthWidth-1:0] length,
  input  logic                   count,
  output logic                   spent
);

  // flits still allowed after the one just accepted.
  logic [lengthWidth-1:0] remaining;

  // spent is a one-cycle pulse after the last allowed flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      remaining <= '0;
      spent <= 1'b0;
    end
    else
    begin
      spent <= 1'b0;
      if (load)
      begin
        // the head itself uses one slot; zero length counts as one.
        if (length > lengthWidth'(1))
          remaining <= length - 1'b1;
        else
        begin
          remaining <= '0;
          spent <= 1'b1;
        end
      end
      else if (count && remaining != '0)
      begin
        remaining <= remaining - 1'b1;
        spent <= (remaining == lengthWidth'(1));
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/inputFifo.sv
`timescale 1ns/1ps
`default_nettype none

module inputFifo #(
  parameter int fifoDepth = 4
) (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::wbReqT req,
  output logic          ack,
  input  logic          pop,
  output nocPkg::flitT  head,
  output logic          notEmpty
);

  localparam int ptrW = $clog2(fifoDepth);

  nocPkg::flitT mem [fifoDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            full;

  assign full = (count == (ptrW + 1)'(fifoDepth));
  assign notEmpty = (count != '0);
  assign head = mem[rdPtr];

  // ack is registered and fires once per bus cycle.
  // the flit is still held by the master while ack is high, so it is stored then.
  always_ff @(posedge clk)
  begin
    if (rst)
      ack <= 1'b0;
    else
      ack <= req.cyc && req.stb && req.we && !ack && !full;
  end

  always_ff @(posedge clk)
  begin
    if (ack)
      mem[wrPtr] <= req.flit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (ack)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({ack, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the arbiter only pops a port that shows data.
  popNeedsData: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty);

  ackSingleCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire

//--- common/nocPkg.sv
`default_nettype none

package nocPkg;

  // input ports of the router, listed in arbitration rotation order.
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portT;

  localparam int numPorts = 5;

  localparam int kindWidth = 3;
  localparam int lengthBits = 12;
  localparam int dataWidth = 32;

  // flit kind flags.
  // a single-flit packet sets head and tail together.
  localparam logic [kindWidth-1:0] kindHead = 3'b001;
  localparam logic [kindWidth-1:0] kindBody = 3'b010;
  localparam logic [kindWidth-1:0] kindTail = 3'b100;

  // one flit, 50 bits.
  // length is only valid in a head flit and counts the whole packet.
  typedef struct packed {
    logic [kindWidth-1:0]  kind;
    logic [lengthBits-1:0] length;
    portT                  srcPort;
    logic [dataWidth-1:0]  data;
  } flitT;

  // request side of one Wishbone classic write.
  // ack runs the other way as a plain bit.
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    flitT flit;
  } wbReqT;

endpackage

`default_nettype wire
